// File: ats21Pkg.sv
/*
  Shared widths, opcodes, rate codes and command structs of the ATS21
  clock, timer and alarm unit. Every RTL file refers to these by scoped
  name (ats21Pkg::name).
*/
`default_nettype none

package ats21Pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes and codes
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_CLOCKS = 16;  // clock counters
  localparam int NUM_ALARMS = 24;  // alarm or timer slots

  // opcode field sits in instr[31:29], upper half [15:13]
  localparam logic [2:0] OP_NOP       = 3'b000;
  localparam logic [2:0] OP_SET_CLOCK = 3'b001;
  localparam logic [2:0] OP_EN_CLOCK  = 3'b010;
  localparam logic [2:0] OP_SET_ALARM = 3'b101;
  localparam logic [2:0] OP_SET_TIMER = 3'b110;
  localparam logic [2:0] OP_EN_ALARM  = 3'b111;

  ////////////////////////////////////////////////////////////////////////////
  // plain vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [15:0] halfWordT;     // one half on ctrlA or ctrlB
  typedef logic [31:0] instrT;        // assembled instruction
  typedef logic [15:0] clockCountT;   // count, alarm value or interval
  typedef logic [3:0]  clockIdxT;     // clock number
  typedef logic [4:0]  alarmIdxT;     // slot number, 24..31 unused
  typedef logic [1:0]  rateT;
  typedef logic [NUM_ALARMS-1:0] dataT;       // fired flag per slot
  typedef logic [NUM_CLOCKS-1:0] clockStepT;  // clock advances this edge

  typedef clockCountT [NUM_CLOCKS-1:0] clockCountsT;  // all counters, 256 bits

  // rate codes, 11 never advances
  localparam rateT RATE_1X = 2'b00;  // every cycle
  localparam rateT RATE_2X = 2'b01;  // every second cycle
  localparam rateT RATE_4X = 2'b10;  // every fourth cycle

  ////////////////////////////////////////////////////////////////////////////
  // state and command types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    waitUpper,  // idle, next non-NOP half is an upper half
    waitLower   // upper half stored
  } captureStateT;

  // one cycle of captured instructions, one word per client
  typedef struct packed {
    logic  validA;
    logic  validB;
    instrT wordA;
    instrT wordB;
  } instrPairT;

  typedef struct packed {
    logic       valid;
    logic       setNotEnable;  // 1 set clock, 0 enable/disable
    clockIdxT   idx;
    rateT       rate;
    logic       enable;
    clockCountT count;         // start count for set
  } clockCmdT;

  typedef struct packed {
    logic       valid;
    logic       setNotEnable;  // 1 set alarm or timer, 0 enable/disable
    alarmIdxT   idx;
    clockIdxT   clock;         // clock the slot watches
    logic       loop;          // repeating alarm
    logic       countdown;     // timer, never repeats
    logic       enable;
    clockCountT value;         // target count, timers already offset
  } alarmCmdT;

endpackage

`default_nettype wire

// File: ats21InstrCapture.sv
/*
  Instruction capture for clients A and B. Each client sends an upper
  half at a req edge and its lower half at the following edge. The
  assembled words leave as one registered pair, valid for one cycle.
*/
`timescale 1ns/100ps
`default_nettype none

module ats21InstrCapture (
  input  logic                clk_1x,
  input  logic                reset,
  input  logic                req,
  input  ats21Pkg::halfWordT  ctrlA,
  input  ats21Pkg::halfWordT  ctrlB,
  output logic                ready,
  output ats21Pkg::instrPairT pair
);

  ats21Pkg::halfWordT     ctrl  [2];  // index 0 is A, 1 is B
  ats21Pkg::halfWordT     upper [2];  // stored upper halves
  ats21Pkg::captureStateT state [2];
  ats21Pkg::instrT        wordQ [2];
  logic [1:0]             validQ;

  assign ctrl[0] = ctrlA;
  assign ctrl[1] = ctrlB;

  // capture FSM per client
  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      for (int c = 0; c < 2; c++) begin
        state[c] <= ats21Pkg::waitUpper;
      end
      validQ <= '0;
    end else begin
      for (int c = 0; c < 2; c++) begin
        validQ[c] <= 1'b0;  // pulse, one cycle only
        case (state[c])
          ats21Pkg::waitUpper: begin
            // a NOP upper half leaves the client idle
            if (req && ctrl[c][15:13] != ats21Pkg::OP_NOP) begin
              state[c] <= ats21Pkg::waitLower;
            end
          end
          default: begin  // lower half taken whatever req is
            validQ[c] <= 1'b1;
            state[c]  <= ats21Pkg::waitUpper;
          end
        endcase
      end
    end
  end

  // halves and words
  always_ff @(posedge clk_1x) begin
    for (int c = 0; c < 2; c++) begin
      if (state[c] == ats21Pkg::waitUpper) begin
        upper[c] <= ctrl[c];
      end else begin
        wordQ[c] <= {upper[c], ctrl[c]};
      end
    end
  end

  assign ready = (state[0] == ats21Pkg::waitUpper) && (state[1] == ats21Pkg::waitUpper);

  always_comb begin
    pair.validA = validQ[0];
    pair.validB = validQ[1];
    pair.wordA  = wordQ[0];
    pair.wordB  = wordQ[1];
  end

  // an accepted upper half drops ready, then the pair shows up
  for (genvar c = 0; c < 2; c++) begin : gFrameChk
    assert property (@(posedge clk_1x) disable iff (reset)
      (ready && req && ctrl[c][15:13] != ats21Pkg::OP_NOP) |=> (!ready ##1 validQ[c]));
  end

endmodule

`default_nettype wire

// File: ats21Arbiter.sv
/*
  Decodes the captured pair, checks the two clients against each other
  and registers stat plus one clock and one alarm command per client.
  Timer targets are the decode-cycle count of the clock plus the interval.
*/
`timescale 1ns/100ps
`default_nettype none

module ats21Arbiter (
  input  logic                  clk_1x,
  input  logic                  reset,
  input  ats21Pkg::instrPairT   pair,
  input  ats21Pkg::clockCountsT counts,
  output logic [1:0]            stat,
  output ats21Pkg::clockCmdT    clockCmd [2],
  output ats21Pkg::alarmCmdT    alarmCmd [2]
);

  logic [1:0]         valid;
  logic               pairValid;
  ats21Pkg::instrT    word       [2];
  logic [2:0]         opcode     [2];
  ats21Pkg::clockIdxT clockField [2];  // instr[28:25]
  ats21Pkg::alarmIdxT slotField  [2];  // instr[28:24]
  ats21Pkg::clockIdxT alarmClock [2];  // instr[19:16]
  logic [1:0]         isClock;
  logic [1:0]         isAlarm;
  logic [1:0]         handled;
  logic [1:0]         ack;
  logic               conflict;
  ats21Pkg::clockCmdT clockNext  [2];
  ats21Pkg::alarmCmdT alarmNext  [2];

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    valid     = {pair.validB, pair.validA};
    word[0]   = pair.wordA;
    word[1]   = pair.wordB;
    pairValid = |valid;

    for (int c = 0; c < 2; c++) begin
      opcode[c]     = valid[c] ? word[c][31:29] : ats21Pkg::OP_NOP;  // missing side is a NOP
      clockField[c] = word[c][28:25];
      slotField[c]  = word[c][28:24];
      alarmClock[c] = word[c][19:16];
      isClock[c]    = (opcode[c] == ats21Pkg::OP_SET_CLOCK) ||
                      (opcode[c] == ats21Pkg::OP_EN_CLOCK);
      isAlarm[c]    = (opcode[c] == ats21Pkg::OP_SET_ALARM) ||
                      (opcode[c] == ats21Pkg::OP_SET_TIMER) ||
                      (opcode[c] == ats21Pkg::OP_EN_ALARM);
      handled[c]    = isClock[c] || isAlarm[c];  // 011 and 100 fall out here
    end

    // same clock or same slot from both sides kills both
    conflict = (&isClock && clockField[0] == clockField[1]) ||
               (&isAlarm && slotField[0] == slotField[1]);
    ack = handled & {2{~conflict}};

    for (int c = 0; c < 2; c++) begin
      clockNext[c].valid        = ack[c] && isClock[c];
      clockNext[c].setNotEnable = opcode[c] == ats21Pkg::OP_SET_CLOCK;
      clockNext[c].idx          = clockField[c];
      clockNext[c].rate         = word[c][23:22];
      clockNext[c].enable       = clockNext[c].setNotEnable || word[c][23];  // set enables
      clockNext[c].count        = word[c][15:0];

      alarmNext[c].valid        = ack[c] && isAlarm[c];
      alarmNext[c].setNotEnable = opcode[c] != ats21Pkg::OP_EN_ALARM;
      alarmNext[c].idx          = slotField[c];
      alarmNext[c].clock        = alarmClock[c];
      alarmNext[c].countdown    = opcode[c] == ats21Pkg::OP_SET_TIMER;
      alarmNext[c].loop         = (opcode[c] == ats21Pkg::OP_SET_ALARM) && word[c][23];
      alarmNext[c].enable       = alarmNext[c].setNotEnable || word[c][23];
      if (alarmNext[c].countdown) begin
        alarmNext[c].value = counts[alarmClock[c]] + word[c][15:0];  // wraps at 16 bits
      end else begin
        alarmNext[c].value = word[c][15:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // status and command registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      stat <= 2'b00;  // Nack, Nack
      for (int c = 0; c < 2; c++) begin
        clockCmd[c] <= '0;
        alarmCmd[c] <= '0;
      end
    end else begin
      if (pairValid) begin
        stat <= ack;  // held until the next pair
      end
      for (int c = 0; c < 2; c++) begin
        clockCmd[c] <= clockNext[c];
        alarmCmd[c] <= alarmNext[c];
      end
    end
  end

  // banks only see commands that were acked
  for (genvar c = 0; c < 2; c++) begin : gAckChk
    assert property (@(posedge clk_1x) disable iff (reset)
      (clockCmd[c].valid || alarmCmd[c].valid) |-> stat[c]);
  end

  assert property (@(posedge clk_1x) disable iff (reset)
    (clockCmd[0].valid && clockCmd[1].valid) |-> (clockCmd[0].idx != clockCmd[1].idx));

endmodule

`default_nettype wire

// File: ats21ClockBank.sv
/*
  Rate divider and the sixteen clock counters. Commands from the
  arbiter win over a tick in the same cycle. step tells the alarm bank
  which counters move at the coming edge.
*/
`timescale 1ns/100ps
`default_nettype none

module ats21ClockBank (
  input  logic                  clk_1x,
  input  logic                  reset,
  input  ats21Pkg::clockCmdT    clockCmd [2],
  output ats21Pkg::clockCountsT counts,
  output ats21Pkg::clockStepT   step
);

  logic [1:0]          divider;                       // free running from reset
  ats21Pkg::rateT      rate [ats21Pkg::NUM_CLOCKS];
  ats21Pkg::clockStepT enable;
  ats21Pkg::clockStepT rateTick;                      // rate allows a tick
  ats21Pkg::clockStepT cmdHit;                        // a command targets the clock

  ////////////////////////////////////////////////////////////////////////////
  // divider
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      divider <= 2'd0;
    end else begin
      divider <= divider + 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tick decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < ats21Pkg::NUM_CLOCKS; i++) begin
      case (rate[i])
        ats21Pkg::RATE_1X: rateTick[i] = 1'b1;
        ats21Pkg::RATE_2X: rateTick[i] = divider[0];  // odd cycles
        ats21Pkg::RATE_4X: rateTick[i] = &divider;    // divider at 3
        default:           rateTick[i] = 1'b0;        // code 11 holds
      endcase
      cmdHit[i] = 1'b0;
      for (int c = 0; c < 2; c++) begin
        if (clockCmd[c].valid && clockCmd[c].idx == ats21Pkg::clockIdxT'(i)) begin
          cmdHit[i] = 1'b1;
        end
      end
    end
  end

  // a commanded clock does not advance this edge
  assign step = enable & rateTick & ~cmdHit;

  ////////////////////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      counts <= '0;
      enable <= '0;
      for (int i = 0; i < ats21Pkg::NUM_CLOCKS; i++) begin
        rate[i] <= ats21Pkg::RATE_1X;
      end
    end else begin
      for (int i = 0; i < ats21Pkg::NUM_CLOCKS; i++) begin
        if (step[i]) begin
          counts[i] <= counts[i] + 1'b1;  // wraps
        end
        for (int c = 0; c < 2; c++) begin
          if (clockCmd[c].valid && clockCmd[c].idx == ats21Pkg::clockIdxT'(i)) begin
            enable[i] <= clockCmd[c].enable;
            if (clockCmd[c].setNotEnable) begin
              counts[i] <= clockCmd[c].count;
              rate[i]   <= clockCmd[c].rate;
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: ats21AlarmBank.sv
/*
  The twenty-four alarm and timer slots. A slot fires when its clock
  steps onto the slot value while the slot is enabled, and its data bit
  is then high for the two cycles after that edge.
*/
`timescale 1ns/100ps
`default_nettype none

module ats21AlarmBank (
  input  logic                  clk_1x,
  input  logic                  reset,
  input  ats21Pkg::alarmCmdT    alarmCmd [2],
  input  ats21Pkg::clockCountsT counts,
  input  ats21Pkg::clockStepT   step,
  output ats21Pkg::dataT        data
);

  ats21Pkg::clockCountT value     [ats21Pkg::NUM_ALARMS];  // target count
  ats21Pkg::clockIdxT   clockSel  [ats21Pkg::NUM_ALARMS];  // watched clock
  ats21Pkg::clockCountT nextCount [ats21Pkg::NUM_ALARMS];  // watched clock plus one
  logic [1:0]           stretch   [ats21Pkg::NUM_ALARMS];  // cycles of data left
  ats21Pkg::dataT       loop;
  ats21Pkg::dataT       countdown;
  ats21Pkg::dataT       enable;
  ats21Pkg::dataT       cmdHit;
  ats21Pkg::dataT       fire;

  ////////////////////////////////////////////////////////////////////////////
  // fire detect
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < ats21Pkg::NUM_ALARMS; i++) begin
      cmdHit[i] = 1'b0;
      for (int c = 0; c < 2; c++) begin
        if (alarmCmd[c].valid && alarmCmd[c].idx == ats21Pkg::alarmIdxT'(i)) begin
          cmdHit[i] = 1'b1;
        end
      end
      nextCount[i] = counts[clockSel[i]] + 1'b1;
      // a command on the slot wins over the tick
      fire[i] = enable[i] && step[clockSel[i]] && (nextCount[i] == value[i]) && !cmdHit[i];
      data[i] = stretch[i] != 2'd0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // slot control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_1x or posedge reset) begin
    if (reset) begin
      loop      <= '0;
      countdown <= '0;
      enable    <= '0;
      for (int i = 0; i < ats21Pkg::NUM_ALARMS; i++) begin
        stretch[i] <= 2'd0;
      end
    end else begin
      for (int i = 0; i < ats21Pkg::NUM_ALARMS; i++) begin
        if (fire[i]) begin
          stretch[i] <= 2'd2;  // high for the next two cycles
          if (!loop[i] || countdown[i]) begin
            enable[i] <= 1'b0;  // one-shot alarms and timers stop
          end
        end else if (stretch[i] != 2'd0) begin
          stretch[i] <= stretch[i] - 2'd1;
        end
        for (int c = 0; c < 2; c++) begin
          if (alarmCmd[c].valid && alarmCmd[c].idx == ats21Pkg::alarmIdxT'(i)) begin
            enable[i] <= alarmCmd[c].enable;
            if (alarmCmd[c].setNotEnable) begin
              loop[i]      <= alarmCmd[c].loop;
              countdown[i] <= alarmCmd[c].countdown;
            end
          end
        end
      end
    end
  end

  // slot payload
  always_ff @(posedge clk_1x) begin
    for (int i = 0; i < ats21Pkg::NUM_ALARMS; i++) begin
      for (int c = 0; c < 2; c++) begin
        if (alarmCmd[c].valid && alarmCmd[c].setNotEnable &&
            alarmCmd[c].idx == ats21Pkg::alarmIdxT'(i)) begin
          value[i]    <= alarmCmd[c].value;
          clockSel[i] <= alarmCmd[c].clock;
        end
      end
    end
  end

  // a third high cycle needs a fresh fire
  for (genvar i = 0; i < ats21Pkg::NUM_ALARMS; i++) begin : gPulseChk
    assert property (@(posedge clk_1x) disable iff (reset)
      (data[i] && $past(data[i]) && $past(data[i], 2)) |-> ($past(fire[i]) || $past(fire[i], 2)));
  end

endmodule

`default_nettype wire

// File: ats21.sv
/*
  ATS21 top level. Capture, arbiter, clock bank and alarm bank in a
  row, all on clk_1x.
*/
`timescale 1ns/100ps
`default_nettype none

module ats21 (
  input  logic               clk_1x,
  input  logic               reset,
  input  logic               req,
  input  ats21Pkg::halfWordT ctrlA,
  input  ats21Pkg::halfWordT ctrlB,
  output logic               ready,
  output logic [1:0]         stat,
  output ats21Pkg::dataT     data
);

  ats21Pkg::instrPairT   pair;
  ats21Pkg::clockCountsT counts;
  ats21Pkg::clockStepT   step;
  ats21Pkg::clockCmdT    clockCmd [2];
  ats21Pkg::alarmCmdT    alarmCmd [2];

  ats21InstrCapture uCapture (
    .clk_1x (clk_1x),
    .reset  (reset),
    .req    (req),
    .ctrlA  (ctrlA),
    .ctrlB  (ctrlB),
    .ready  (ready),
    .pair   (pair)
  );

  ats21Arbiter uArbiter (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .pair     (pair),
    .counts   (counts),
    .stat     (stat),
    .clockCmd (clockCmd),
    .alarmCmd (alarmCmd)
  );

  ats21ClockBank uClockBank (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .clockCmd (clockCmd),
    .counts   (counts),
    .step     (step)
  );

  ats21AlarmBank uAlarmBank (
    .clk_1x   (clk_1x),
    .reset    (reset),
    .alarmCmd (alarmCmd),
    .counts   (counts),
    .step     (step),
    .data     (data)
  );

endmodule

`default_nettype wire

// File: ats21Tb.sv
/*
  Testbench for the ATS21 clock, timer and alarm unit. Reads instruction
  frames and expected results from ats21Input.txt, drives both clients,
  then checks ready, stat and the data pulses. Run from the project root.
*/
`timescale 1ns/100ps
`default_nettype none

module ats21Tb;

  localparam int FIELDS     = 8;   // words per frame line
  localparam int MAX_FRAMES = 64;

  logic               clk_1x;
  logic               reset;
  logic               req;
  ats21Pkg::halfWordT ctrlA;
  ats21Pkg::halfWordT ctrlB;
  logic               ready;
  logic [1:0]         stat;
  ats21Pkg::dataT     data;

  logic [31:0] stim [0:FIELDS*MAX_FRAMES-1];  // unread entries stay x
  int          frameCount;
  int          maxIdle;    // longest wait in the file
  int          checkCount;
  int          errorCount;

  ats21 UUT (
    .clk_1x (clk_1x),
    .reset  (reset),
    .req    (req),
    .ctrlA  (ctrlA),
    .ctrlB  (ctrlB),
    .ready  (ready),
    .stat   (stat),
    .data   (data)
  );

  always #5 clk_1x = ~clk_1x;  // 10 ns period

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("error: time %0t, %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // both clients back in waitUpper
  task automatic waitReady();
    while (ready !== 1'b1) begin
      @(posedge clk_1x);
      #1;
    end
  endtask

  task automatic runFrame(input int f);
    logic [31:0] upA;
    logic [31:0] loA;
    logic [31:0] upB;
    logic [31:0] loB;
    logic [31:0] expStat;
    logic [31:0] idle;
    logic [31:0] expData;
    logic [31:0] sample;
    logic        expReady;
    int          k;
    upA     = stim[f*FIELDS];
    loA     = stim[f*FIELDS+1];
    upB     = stim[f*FIELDS+2];
    loB     = stim[f*FIELDS+3];
    expStat = stim[f*FIELDS+4];
    idle    = stim[f*FIELDS+5];
    expData = stim[f*FIELDS+6];
    sample  = stim[f*FIELDS+7];
    // a NOP upper half keeps that client idle
    expReady = (upA[15:13] == ats21Pkg::OP_NOP) && (upB[15:13] == ats21Pkg::OP_NOP);
    if (sample > idle) begin
      errorCount++;
      $display("frame %0d samples data outside its wait, check skipped", f);
    end

    waitReady();
    req   = 1'b1;  // upper halves
    ctrlA = upA[15:0];
    ctrlB = upB[15:0];
    @(posedge clk_1x);  // T0
    #1;
    checkValue("ready", {31'd0, expReady}, {31'd0, ready});
    req = 1'b0;
    if (!expReady) begin
      ctrlA = loA[15:0];  // taken at T1 whatever req is
      ctrlB = loB[15:0];
      @(posedge clk_1x);  // T1
      #1;
      ctrlA = '0;
      ctrlB = '0;
      @(posedge clk_1x);  // T2, stat registered here
      #1;
      checkValue("ready", 32'd1, {31'd0, ready});
    end else begin
      ctrlA = '0;
      ctrlB = '0;
    end
    checkValue("stat", expStat, {30'd0, stat});  // held value for idle frames

    // idle cycles, data compared at one of them
    for (k = 0; k <= idle; k++) begin
      if (k == sample) begin
        checkValue("data", expData, {8'd0, data});
      end
      if (k < idle) begin
        @(posedge clk_1x);
        #1;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_1x     = 1'b0;
    reset      = 1'b1;
    req        = 1'b0;
    ctrlA      = '0;
    ctrlB      = '0;
    checkCount = 0;
    errorCount = 0;
    frameCount = 0;
    maxIdle    = 0;

    $readmemh("ats21Input.txt", stim);
    while (frameCount < MAX_FRAMES && !$isunknown(stim[frameCount*FIELDS])) begin
      if (stim[frameCount*FIELDS+5] > maxIdle) begin
        maxIdle = stim[frameCount*FIELDS+5];
      end
      frameCount++;
    end

    repeat (5) @(posedge clk_1x);
    #1;
    reset = 1'b0;

    // values straight out of reset
    checkValue("ready", 32'd1, {31'd0, ready});
    checkValue("stat", 32'd0, {30'd0, stat});
    checkValue("data", 32'd0, {8'd0, data});

    if (frameCount == 0) begin
      errorCount++;
      $display("no stimulus frames found in ats21Input.txt");
    end
    for (int f = 0; f < frameCount; f++) begin
      runFrame(f);
    end

    $display("checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // frames times the longest frame, plus margin for reset
  initial begin : watchdog
    int limit;
    #1;
    limit = frameCount * (3 + maxIdle) + 50;
    repeat (limit) @(posedge clk_1x);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: ats21Input.txt
// upperA lowerA upperB lowerB stat idle data sample, all hex
// sample counts cycles after the last handshake edge, 0 to idle
2600 0100 2A00 0000 3 1 000000 1  // clock 3 and clock 5 at 1x
2600 5555 2600 0000 0 1 000000 1  // both set clock 3, conflict
A203 010D A483 010D 3 6 000014 6  // slot 2 one-shot, slot 4 loop, clock 3
0000 0000 0000 0000 3 0 000014 0  // second pulse cycle
0000 0000 0000 0000 3 0 000000 0  // pulse over
2600 0100 0000 0000 1 E 000010 E  // clock 3 back to 100, only slot 4 again
0000 0000 0000 0000 1 0 000010 0
C705 000A 2C40 0000 3 9 000080 9  // timer slot 7 on clock 5, clock 6 at 2x
0000 0000 0000 0000 3 0 000080 0
A705 0050 C705 0003 0 1 000000 1  // alarm and timer on slot 7, conflict
AA05 0042 AC06 000C 3 1 000000 1  // slot 10 on clock 5, slot 12 on clock 6
EA00 0000 2E80 0000 3 3 001000 3  // slot 10 off, clock 7 at 4x
0000 0000 0000 0000 3 0 001000 0
AD07 0005 AE05 0060 3 2 000000 2  // slot 13 on clock 7, slot 14 on clock 5
4A00 0000 6000 1234 1 7 002000 7  // clock 5 off, opcode 011 nacked
0000 0000 0000 0000 1 0 002000 0
8000 0000 0000 0000 0 10 000000 10  // opcode 100 nacked, slot 14 silent
0000 0000 0000 0000 0 0 000000 0

// File: ats21.f
ats21Pkg.sv
ats21InstrCapture.sv
ats21Arbiter.sv
ats21ClockBank.sv
ats21AlarmBank.sv
ats21.sv
ats21Tb.sv

// File: Bender.yml
package:
  name: ats21

sources:
  - ats21Pkg.sv
  - ats21InstrCapture.sv
  - ats21Arbiter.sv
  - ats21ClockBank.sv
  - ats21AlarmBank.sv
  - ats21.sv
  - target: test
    files:
      - ats21Tb.sv
